//--- design/clint_pkg.sv
`default_nettype none

package clint_pkg;

    // axi-lite bus widths
    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    localparam int axi_strb_w = 4;

    // register map, decoded on the low 16 address bits
    localparam logic [15:0] off_msip        = 16'h0000;
    localparam logic [15:0] off_mtimecmp_lo = 16'h4000;
    localparam logic [15:0] off_mtimecmp_hi = 16'h4004;
    localparam logic [15:0] off_mtime_lo    = 16'hBFF8;
    localparam logic [15:0] off_mtime_hi    = 16'hBFFC;

    // bus response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // read channel FSM
    typedef enum logic [1:0] {
        rd_idle,
        rd_wait,
        rd_resp
    } rd_state_e;

    // write channel FSM
    typedef enum logic [1:0] {
        wr_collect,
        wr_commit,
        wr_resp
    } wr_state_e;

    // read delay lfsr start value, must be nonzero
    localparam logic [2:0] lfsr_seed = 3'b001;

endpackage

`default_nettype wire

//--- design/axil_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_read_port (
    input  wire                              clk,
    input  wire                              rst_n,
    // AR channel
    input  wire  [clint_pkg::axi_addr_w-1:0] araddr,
    input  wire                              arvalid,
    output logic                             arready,
    // R channel
    output logic [clint_pkg::axi_data_w-1:0] rdata,
    output clint_pkg::axi_resp_e             rresp,
    output logic                             rvalid,
    input  wire                              rready,
    // register file side
    output logic [clint_pkg::axi_addr_w-1:0] rd_addr,
    input  wire  [clint_pkg::axi_data_w-1:0] rd_data,
    input  wire                              rd_err
);
    import clint_pkg::*;

    rd_state_e  state;
    logic [2:0] lfsr;
    logic [2:0] delay;
    logic [2:0] wait_cnt;
    logic       ar_fire;
    logic       wait_done;

    assign arready   = (state == rd_idle);
    assign rvalid    = (state == rd_resp);
    assign ar_fire   = arvalid && arready;
    assign wait_done = (state == rd_wait) && (wait_cnt == delay);

    // x^3 + x^2 + 1, steps only while idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= lfsr_seed;
        end else if (state == rd_idle) begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= rd_idle;
            delay    <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                rd_idle: begin
                    if (ar_fire) begin
                        // lfsr never holds zero, so delay is 1..7
                        delay    <= lfsr;
                        wait_cnt <= 3'd1;
                        state    <= rd_wait;
                    end
                end
                rd_wait: begin
                    if (wait_done) begin
                        state <= rd_resp;
                    end else begin
                        wait_cnt <= wait_cnt + 3'd1;
                    end
                end
                rd_resp: begin
                    if (rready) begin
                        state <= rd_idle;
                    end
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    // address latch and response capture
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
        end
        if (wait_done) begin
            rdata <= rd_err ? '0 : rd_data;
            rresp <= rd_err ? resp_slverr : resp_okay;
        end
    end

endmodule

`default_nettype wire

//--- design/axil_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_write_port (
    input  wire                              clk,
    input  wire                              rst_n,
    // AW channel
    input  wire  [clint_pkg::axi_addr_w-1:0] awaddr,
    input  wire                              awvalid,
    output logic                             awready,
    // W channel
    input  wire  [clint_pkg::axi_data_w-1:0] wdata,
    input  wire  [clint_pkg::axi_strb_w-1:0] wstrb,
    input  wire                              wvalid,
    output logic                             wready,
    // B channel
    output clint_pkg::axi_resp_e             bresp,
    output logic                             bvalid,
    input  wire                              bready,
    // register file side
    output logic                             wr_stb,
    output logic [clint_pkg::axi_addr_w-1:0] wr_addr,
    output logic [clint_pkg::axi_data_w-1:0] wr_data,
    output logic [clint_pkg::axi_strb_w-1:0] wr_strb,
    input  wire                              wr_err
);
    import clint_pkg::*;

    wr_state_e state;
    logic      aw_held;
    logic      w_held;
    logic      aw_fire;
    logic      w_fire;
    logic      have_aw;
    logic      have_w;

    // readies drop once a channel is captured and stay low until B completes
    assign awready = (state == wr_collect) && !aw_held;
    assign wready  = (state == wr_collect) && !w_held;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign have_aw = aw_held || aw_fire;
    assign have_w  = w_held || w_fire;

    assign wr_stb = (state == wr_commit);
    assign bvalid = (state == wr_resp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= wr_collect;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            case (state)
                wr_collect: begin
                    if (aw_fire) begin
                        aw_held <= 1'b1;
                    end
                    if (w_fire) begin
                        w_held <= 1'b1;
                    end
                    if (have_aw && have_w) begin
                        state <= wr_commit;
                    end
                end
                wr_commit: begin
                    state <= wr_resp;
                end
                wr_resp: begin
                    if (bready) begin
                        aw_held <= 1'b0;
                        w_held  <= 1'b0;
                        state   <= wr_collect;
                    end
                end
                default: begin
                    state <= wr_collect;
                end
            endcase
        end
    end

    // hold registers, filled in whichever order the channels arrive
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr <= awaddr;
        end
        if (w_fire) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
    end

    // decode answer is valid during the strobe cycle
    always_ff @(posedge clk) begin
        if (state == wr_commit) begin
            bresp <= wr_err ? resp_slverr : resp_okay;
        end
    end

endmodule

`default_nettype wire

//--- design/clint_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clint_regs (
    input  wire                              clk,
    input  wire                              rst_n,
    // read side
    input  wire  [clint_pkg::axi_addr_w-1:0] rd_addr,
    output logic [clint_pkg::axi_data_w-1:0] rd_data,
    output logic                             rd_err,
    // write side
    input  wire                              wr_stb,
    input  wire  [clint_pkg::axi_addr_w-1:0] wr_addr,
    input  wire  [clint_pkg::axi_data_w-1:0] wr_data,
    input  wire  [clint_pkg::axi_strb_w-1:0] wr_strb,
    output logic                             wr_err,
    // interrupt sources
    output logic [63:0]                      mtime,
    output logic [63:0]                      mtimecmp,
    output logic                             msip_bit
);
    import clint_pkg::*;

    logic [15:0] rd_off;
    logic [15:0] wr_off;
    logic        sel_msip;
    logic        sel_cmp_lo;
    logic        sel_cmp_hi;
    logic        sel_time_lo;
    logic        sel_time_hi;
    logic        tick;

    // replace only the bytes whose strobe is set
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign rd_off = rd_addr[15:0];
    assign wr_off = wr_addr[15:0];

    // read decode
    always_comb begin
        rd_err = 1'b0;
        case (rd_off)
            off_msip:        rd_data = {31'b0, msip_bit};
            off_mtimecmp_lo: rd_data = mtimecmp[31:0];
            off_mtimecmp_hi: rd_data = mtimecmp[63:32];
            off_mtime_lo:    rd_data = mtime[31:0];
            off_mtime_hi:    rd_data = mtime[63:32];
            default: begin
                rd_data = '0;
                rd_err  = 1'b1;
            end
        endcase
    end

    // write decode
    assign sel_msip    = wr_stb && (wr_off == off_msip);
    assign sel_cmp_lo  = wr_stb && (wr_off == off_mtimecmp_lo);
    assign sel_cmp_hi  = wr_stb && (wr_off == off_mtimecmp_hi);
    assign sel_time_lo = wr_stb && (wr_off == off_mtime_lo);
    assign sel_time_hi = wr_stb && (wr_off == off_mtime_hi);

    assign wr_err = !((wr_off == off_msip) || (wr_off == off_mtimecmp_lo) ||
                      (wr_off == off_mtimecmp_hi) || (wr_off == off_mtime_lo) ||
                      (wr_off == off_mtime_hi));

    // timer, advances every second clock; a bus write wins over the increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= ~tick;
            if (sel_time_lo) begin
                mtime[31:0] <= merge_bytes(mtime[31:0], wr_data, wr_strb);
            end else if (sel_time_hi) begin
                mtime[63:32] <= merge_bytes(mtime[63:32], wr_data, wr_strb);
            end else if (tick) begin
                mtime <= mtime + 64'd1;
            end
        end
    end

    // compare value starts at max so no timer irq after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else begin
            if (sel_cmp_lo) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], wr_data, wr_strb);
            end
            if (sel_cmp_hi) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], wr_data, wr_strb);
            end
        end
    end

    // only bit 0 exists
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msip_bit <= 1'b0;
        end else if (sel_msip && wr_strb[0]) begin
            msip_bit <= wr_data[0];
        end
    end

endmodule

`default_nettype wire

//--- design/clint_irq_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clint_irq_gen (
    input  wire        clk,
    input  wire        rst_n,
    input  wire [63:0] mtime,
    input  wire [63:0] mtimecmp,
    input  wire        msip_bit,
    output logic       mtip,
    output logic       msip
);

    logic timer_hit;

    // unsigned compare, level while time has reached the compare value
    assign timer_hit = (mtime >= mtimecmp);

    // both lines come straight from flops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtip <= 1'b0;
            msip <= 1'b0;
        end else begin
            mtip <= timer_hit;
            msip <= msip_bit;
        end
    end

endmodule

`default_nettype wire

//--- design/clint_top.sv
`timescale 1ns/1ps
`default_nettype none

module clint_top (
    input  wire                              clk,
    input  wire                              rst_n,
    // AR
    input  wire  [clint_pkg::axi_addr_w-1:0] araddr,
    input  wire                              arvalid,
    output logic                             arready,
    // R
    output logic [clint_pkg::axi_data_w-1:0] rdata,
    output clint_pkg::axi_resp_e             rresp,
    output logic                             rvalid,
    input  wire                              rready,
    // AW
    input  wire  [clint_pkg::axi_addr_w-1:0] awaddr,
    input  wire                              awvalid,
    output logic                             awready,
    // W
    input  wire  [clint_pkg::axi_data_w-1:0] wdata,
    input  wire  [clint_pkg::axi_strb_w-1:0] wstrb,
    input  wire                              wvalid,
    output logic                             wready,
    // B
    output clint_pkg::axi_resp_e             bresp,
    output logic                             bvalid,
    input  wire                              bready,
    // interrupts
    output logic                             mtip,
    output logic                             msip
);
    import clint_pkg::*;

    logic [axi_addr_w-1:0] rd_addr;
    logic [axi_data_w-1:0] rd_data;
    logic                  rd_err;
    logic                  wr_stb;
    logic [axi_addr_w-1:0] wr_addr;
    logic [axi_data_w-1:0] wr_data;
    logic [axi_strb_w-1:0] wr_strb;
    logic                  wr_err;
    logic [63:0]           mtime;
    logic [63:0]           mtimecmp;
    logic                  msip_bit;

    axil_read_port rd_port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_err  (rd_err)
    );

    axil_write_port wr_port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_stb  (wr_stb),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .wr_err  (wr_err)
    );

    clint_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_err   (rd_err),
        .wr_stb   (wr_stb),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .wr_err   (wr_err),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .msip_bit (msip_bit)
    );

    clint_irq_gen irq_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .msip_bit (msip_bit),
        .mtip     (mtip),
        .msip     (msip)
    );

endmodule

`default_nettype wire

//--- bench/clint_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clint_tb;
    import clint_pkg::*;

    // the six tests take about 700 cycles, so this leaves a wide margin
    localparam int max_cycles = 5000;
    localparam logic [31:0] unmapped_addr = 32'h0000_0100;
    localparam logic [31:0] cmp_target = 32'h0000_0060;

    logic                  clk;
    logic                  rst_n;
    logic [axi_addr_w-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [axi_data_w-1:0] rdata;
    axi_resp_e             rresp;
    logic                  rvalid;
    logic                  rready;
    logic [axi_addr_w-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [axi_data_w-1:0] wdata;
    logic [axi_strb_w-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    axi_resp_e             bresp;
    logic                  bvalid;
    logic                  bready;
    logic                  mtip;
    logic                  msip;

    int          cycle = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    logic [31:0] rng = 32'd3;

    clint_top clint_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .mtip    (mtip),
        .msip    (msip)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cycle count, also used by the timer tests
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("timeout: tests did not finish within %0d clock cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    task automatic check_data(input string what, input logic [axi_data_w-1:0] got,
                              input logic [axi_data_w-1:0] exp);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_range(input string what, input logic [axi_data_w-1:0] got,
                               input logic [axi_data_w-1:0] lo,
                               input logic [axi_data_w-1:0] hi);
        if (got >= lo && got <= hi) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h..0x%08h",
                     $time, what, got, lo, hi);
        end
    endtask

    task automatic check_resp(input string what, input axi_resp_e got, input axi_resp_e exp);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("[ERROR] %0t ns: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_cnt == fails_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, fail_cnt - fails_before);
        end
    endtask

    // every driver task starts and ends just after a falling edge
    task automatic send_aw(input logic [31:0] addr);
        awaddr  = addr;
        awvalid = 1'b1;
        while (!awready) begin
            @(negedge clk);
        end
        @(negedge clk);
        awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        while (!wready) begin
            @(negedge clk);
        end
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output axi_resp_e resp);
        int order;
        int delay;
        order = rand_below(3);
        delay = rand_below(4);
        case (order)
            0: begin
                send_aw(addr);
                send_w(data, strb);
            end
            1: begin
                send_w(data, strb);
                send_aw(addr);
            end
            default: begin
                fork
                    send_aw(addr);
                    send_w(data, strb);
                join
            end
        endcase
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        repeat (delay) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        int          delay;
        logic [31:0] first;
        delay   = rand_below(4);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge clk);
        end
        first = rdata;
        repeat (delay) @(negedge clk);
        // data must not move while the master stalls
        check_data("rdata held under back-pressure", rdata, first);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic test_reset();
        int          fails_before;
        logic [31:0] data;
        axi_resp_e   resp;
        fails_before = fail_cnt;
        check_bit("mtip after reset", mtip, 1'b0);
        check_bit("msip after reset", msip, 1'b0);
        check_bit("rvalid after reset", rvalid, 1'b0);
        check_bit("bvalid after reset", bvalid, 1'b0);
        check_bit("arready after reset", arready, 1'b1);
        check_bit("awready after reset", awready, 1'b1);
        check_bit("wready after reset", wready, 1'b1);
        axi_read({16'h0, off_mtimecmp_lo}, data, resp);
        check_data("mtimecmp_lo after reset", data, 32'hFFFF_FFFF);
        check_resp("mtimecmp_lo read response", resp, resp_okay);
        axi_read({16'h0, off_mtimecmp_hi}, data, resp);
        check_data("mtimecmp_hi after reset", data, 32'hFFFF_FFFF);
        check_resp("mtimecmp_hi read response", resp, resp_okay);
        report_test("test 1 reset values", fails_before);
    endtask

    task automatic test_software_irq();
        int          fails_before;
        logic [31:0] data;
        axi_resp_e   resp;
        fails_before = fail_cnt;
        axi_write({16'h0, off_msip}, 32'h1, 4'hF, resp);
        check_resp("msip set write response", resp, resp_okay);
        check_bit("msip line after set", msip, 1'b1);
        axi_read({16'h0, off_msip}, data, resp);
        check_data("msip readback after set", data, 32'h1);
        check_resp("msip read response", resp, resp_okay);
        axi_write({16'h0, off_msip}, 32'h0, 4'hF, resp);
        check_resp("msip clear write response", resp, resp_okay);
        check_bit("msip line after clear", msip, 1'b0);
        axi_read({16'h0, off_msip}, data, resp);
        check_data("msip readback after clear", data, 32'h0);
        // upper bits are not stored
        axi_write({16'h0, off_msip}, 32'hFFFF_FFFE, 4'hF, resp);
        check_resp("msip upper bits write response", resp, resp_okay);
        axi_read({16'h0, off_msip}, data, resp);
        check_data("msip readback after upper bits", data, 32'h0);
        check_bit("msip line after upper bits", msip, 1'b0);
        report_test("test 2 software interrupt", fails_before);
    endtask

    task automatic test_timer_advance();
        int          fails_before;
        int          t0;
        logic [31:0] data;
        logic [31:0] first;
        axi_resp_e   resp;
        fails_before = fail_cnt;
        axi_write({16'h0, off_mtime_hi}, 32'h0, 4'hF, resp);
        check_resp("mtime_hi write response", resp, resp_okay);
        t0 = cycle;
        axi_write({16'h0, off_mtime_lo}, 32'h100, 4'hF, resp);
        check_resp("mtime_lo write response", resp, resp_okay);
        axi_read({16'h0, off_mtime_lo}, data, resp);
        check_resp("mtime_lo read response", resp, resp_okay);
        check_range("mtime_lo after write", data, 32'h100, 32'h100 + 32'(cycle - t0));
        first = data;
        axi_read({16'h0, off_mtime_lo}, data, resp);
        check_range("mtime_lo second read", data, first + 32'd1, 32'hFFFF_FFFF);
        report_test("test 3 timer write and advance", fails_before);
    endtask

    task automatic test_timer_irq();
        int          fails_before;
        int          t_start;
        int          t_zero;
        int          deadline;
        logic [31:0] data;
        axi_resp_e   resp;
        fails_before = fail_cnt;
        axi_write({16'h0, off_mtimecmp_hi}, 32'hFFFF_FFFF, 4'hF, resp);
        check_resp("mtimecmp_hi write response", resp, resp_okay);
        t_start = cycle;
        axi_write({16'h0, off_mtime_lo}, 32'h0, 4'hF, resp);
        axi_write({16'h0, off_mtime_hi}, 32'h0, 4'hF, resp);
        t_zero = cycle;
        axi_write({16'h0, off_mtimecmp_lo}, cmp_target, 4'hF, resp);
        check_bit("mtip with compare high half max", mtip, 1'b0);
        axi_write({16'h0, off_mtimecmp_hi}, 32'h0, 4'hF, resp);
        check_resp("mtimecmp_hi clear response", resp, resp_okay);
        // timer counts every second cycle, plus one cycle through the output flop
        deadline = t_zero + 2 * int'(cmp_target) + 4;
        while (!mtip && cycle < deadline) begin
            @(negedge clk);
        end
        check_bit("mtip after compare reached", mtip, 1'b1);
        axi_read({16'h0, off_mtime_lo}, data, resp);
        check_range("mtime_lo after mtip", data, cmp_target, 32'(cycle - t_start));
        axi_write({16'h0, off_mtimecmp_hi}, 32'hFFFF_FFFF, 4'hF, resp);
        check_bit("mtip after compare raised", mtip, 1'b0);
        report_test("test 4 timer interrupt", fails_before);
    endtask

    task automatic test_byte_strobes();
        int          fails_before;
        logic [31:0] data;
        axi_resp_e   resp;
        fails_before = fail_cnt;
        axi_write({16'h0, off_mtimecmp_lo}, 32'hFFFF_FFFF, 4'hF, resp);
        axi_write({16'h0, off_mtimecmp_lo}, 32'h1122_3344, 4'b0101, resp);
        check_resp("strobed write response", resp, resp_okay);
        axi_read({16'h0, off_mtimecmp_lo}, data, resp);
        check_data("mtimecmp_lo after strobed write", data, 32'hFF22_FF44);
        check_resp("strobed readback response", resp, resp_okay);
        report_test("test 5 byte strobes", fails_before);
    endtask

    task automatic test_unmapped();
        int          fails_before;
        logic [31:0] data;
        axi_resp_e   resp;
        fails_before = fail_cnt;
        axi_write(unmapped_addr, 32'hFFFF_FFFF, 4'hF, resp);
        check_resp("unmapped write response", resp, resp_slverr);
        axi_read(unmapped_addr, data, resp);
        check_resp("unmapped read response", resp, resp_slverr);
        check_data("unmapped read data", data, 32'h0);
        // nothing may have moved
        axi_read({16'h0, off_msip}, data, resp);
        check_resp("mapped read after error", resp, resp_okay);
        check_data("msip after unmapped write", data, 32'h0);
        axi_read({16'h0, off_mtimecmp_lo}, data, resp);
        check_data("mtimecmp_lo after unmapped write", data, 32'hFF22_FF44);
        axi_read({16'h0, off_mtimecmp_hi}, data, resp);
        check_data("mtimecmp_hi after unmapped write", data, 32'hFFFF_FFFF);
        check_bit("msip line after unmapped write", msip, 1'b0);
        report_test("test 6 unmapped offset", fails_before);
    endtask

    initial begin
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        // four rising edges under reset, release on the falling edge after
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_software_irq();
        test_timer_advance();
        test_timer_irq();
        test_byte_strobes();
        test_unmapped();
        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/clint_pkg.sv
design/axil_read_port.sv
design/axil_write_port.sv
design/clint_regs.sv
design/clint_irq_gen.sv
design/clint_top.sv
bench/clint_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the CLINT testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
top=clint_tb

verilator --binary --timing --timescale 1ns/1ps --top-module "$top" \
    -f verilog.f -Mdir obj_dir -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$log"; then
    echo "no result line found in $log"
    exit 1
fi
exit 0
